//--- Makefile
# Verilator build and run for the memory and write-back pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_wb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the testbench printed the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf $(OBJ_DIR)

//--- logic/data_mem.sv
`timescale 1ns/100ps

module data_mem import pipe_pkg::*; #(
    parameter int DMEM_WORDS = 256                  // depth in words, set from the top level
) (
    input  logic         clk,
    input  logic         rst_n,

    input  mem_ctrl_t    mem_ctrl,                  // from ex_mem_reg
    input  hazard_ctrl_t hazard_control,            // hold blocks the write

    input  word_t        mem_alu_result,            // byte address of load/store
    input  word_t        mem_store_data,            // store payload

    output word_t        mem_read_data              // for mem_wb_reg, valid same cycle
);

    localparam int WORD_IDX_WIDTH = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

    word_t                     mem [DMEM_WORDS];    // word storage
    logic [WORD_IDX_WIDTH-1:0] word_idx;            // selected word
    logic                      write_en;

    // byte offset dropped, upper address bits alias modulo the depth
    assign word_idx = WORD_IDX_WIDTH'((mem_alu_result >> 2) % DMEM_WORDS);

    // a real store that is not frozen by halt
    assign write_en = mem_ctrl.mem_write_enable
                    & ~mem_ctrl.no_op
                    & ~hazard_control[HAZD_HOLD_BIT];

    assign mem_read_data = mem[word_idx];           // asynchronous read

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem[i] <= '0;                       // contents start at zero
            end
        end else if (write_en) begin
            mem[word_idx] <= mem_store_data;
        end
    end

endmodule

//--- logic/ex_mem_reg.sv
`timescale 1ns/100ps

module ex_mem_reg import pipe_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,

    input  hazard_ctrl_t hazard_control,    // from hazard_unit, hold and bubble request
    input  logic         ex_valid,          // execute presents an instruction this cycle

    input  mem_ctrl_t    ex_ctrl,           // control of the execute-stage instruction
    output mem_ctrl_t    mem_ctrl,          // for data_mem, mem_wb_reg, forwarding, hazard

    input  word_t        ex_alu_result,     // alu value, or address of load/store
    output word_t        mem_alu_result,

    input  word_t        ex_store_data,     // store payload, operand b
    output word_t        mem_store_data,    // for data_mem

    input  reg_idx_t     ex_dest_reg_idx,   // destination of the execute-stage instruction
    output reg_idx_t     mem_dest_reg_idx   // for forwarding and load-use check
);

    logic      bubble;                      // nothing real enters memory this edge
    mem_ctrl_t next_ctrl;                   // control as it will be latched

    // a squashed, stalled or absent instruction turns into an empty slot
    assign bubble = hazard_control[HAZD_NO_OP_BIT] | ~ex_valid | ex_ctrl.no_op;

    always_comb begin
        next_ctrl = ex_ctrl;
        if (bubble) begin
            next_ctrl = MEM_CTRL_BUBBLE;    // enables dropped with the no-op flag
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_ctrl         <= MEM_CTRL_BUBBLE;  // come out of reset empty
            mem_alu_result   <= '0;
            mem_store_data   <= '0;
            mem_dest_reg_idx <= '0;
        end else if (!hazard_control[HAZD_HOLD_BIT]) begin
            mem_ctrl         <= next_ctrl;
            mem_alu_result   <= ex_alu_result;     // payload follows even on bubbles
            mem_store_data   <= ex_store_data;
            mem_dest_reg_idx <= ex_dest_reg_idx;
        end
        // on hold the memory-stage instruction stays put
    end

endmodule

//--- logic/forwarding_unit.sv
`timescale 1ns/100ps

module forwarding_unit import pipe_pkg::*; (
    input  reg_idx_t  ex_src_a_idx,         // sources of the execute-stage instruction
    input  reg_idx_t  ex_src_b_idx,

    input  mem_ctrl_t mem_ctrl,             // memory-stage instruction
    input  word_t     mem_alu_result,
    input  reg_idx_t  mem_dest_reg_idx,

    input  logic      wb_no_op,             // write-back instruction
    input  logic      wb_reg_write_enable,
    input  reg_idx_t  wb_dest_reg_idx,
    input  word_t     wb_data,              // already selected by general_reg

    input  word_t     rd_a_data,            // register file values
    input  word_t     rd_b_data,

    output word_t     operand_a,            // newest architectural values
    output word_t     operand_b
);

    logic mem_fwd_ok;                       // memory stage holds a final result
    logic wb_fwd_ok;                        // write-back will write this edge

    // a load in memory has no value yet, the hazard unit stalls for it
    assign mem_fwd_ok = mem_ctrl.reg_write_enable & ~mem_ctrl.no_op
                      & ~mem_ctrl.mem_read_enable & (mem_dest_reg_idx != '0);
    assign wb_fwd_ok  = wb_reg_write_enable & ~wb_no_op & (wb_dest_reg_idx != '0);

    // newest writer wins: memory, then write-back, then register file
    function automatic word_t pick_operand(input reg_idx_t src, input word_t rf_data);
        word_t value;
        value = rf_data;
        if (mem_fwd_ok && (mem_dest_reg_idx == src)) begin
            value = mem_alu_result;
        end else if (wb_fwd_ok && (wb_dest_reg_idx == src)) begin
            value = wb_data;
        end
        return value;
    endfunction

    always_comb begin
        operand_a = pick_operand(ex_src_a_idx, rd_a_data);
        operand_b = pick_operand(ex_src_b_idx, rd_b_data);
    end

endmodule

//--- logic/general_reg.sv
`timescale 1ns/100ps

module general_reg import pipe_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,

    input  logic     wb_no_op,              // from mem_wb_reg
    input  logic     wb_reg_write_enable,
    input  logic     wb_mem_read_enable,    // load, take memory data
    input  word_t    wb_alu_result,
    input  word_t    wb_mem_read_data,
    input  reg_idx_t wb_dest_reg_idx,

    input  reg_idx_t rd_a_idx,              // source a of the execute stage
    input  reg_idx_t rd_b_idx,              // source b of the execute stage
    output word_t    rd_a_data,
    output word_t    rd_b_data,

    output word_t    wb_data                // selected write-back value, also forwarded
);

    localparam int REG_COUNT = 1 << REG_FILE_ADDR_WIDTH;

    word_t regs [REG_COUNT];                // register storage, entry 0 never written
    logic  write_en;

    // write-back select, loads return memory data
    assign wb_data = wb_mem_read_enable ? wb_mem_read_data : wb_alu_result;

    assign write_en = wb_reg_write_enable & ~wb_no_op & (wb_dest_reg_idx != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[wb_dest_reg_idx] <= wb_data;
        end
    end

    // combinational reads, register zero pinned to zero
    assign rd_a_data = (rd_a_idx == '0) ? '0 : regs[rd_a_idx];
    assign rd_b_data = (rd_b_idx == '0) ? '0 : regs[rd_b_idx];

endmodule

//--- logic/hazard_unit.sv
`timescale 1ns/100ps

module hazard_unit import pipe_pkg::*; (
    input  logic         ex_valid,          // execute presents an instruction
    input  reg_idx_t     ex_src_a_idx,
    input  reg_idx_t     ex_src_b_idx,

    input  mem_ctrl_t    mem_ctrl,          // memory-stage instruction
    input  reg_idx_t     mem_dest_reg_idx,

    input  logic         halt,              // external freeze, level
    input  logic         flush,             // squash execute-stage instruction, level

    output logic         stall,             // execute must re-present next cycle
    output hazard_ctrl_t ex_mem_hazard,     // for ex_mem_reg and data_mem
    output hazard_ctrl_t mem_wb_hazard      // for mem_wb_reg
);

    logic load_in_mem;                      // memory stage is a load to a real register
    logic src_match;                        // execute reads that register
    logic load_use;

    assign load_in_mem = mem_ctrl.mem_read_enable & mem_ctrl.reg_write_enable
                       & ~mem_ctrl.no_op & (mem_dest_reg_idx != '0);

    assign src_match = (ex_src_a_idx == mem_dest_reg_idx)
                     | (ex_src_b_idx == mem_dest_reg_idx);

    // clears by itself one edge later when the load moves to write-back
    assign load_use = ex_valid & load_in_mem & src_match;

    assign stall = load_use | halt;

    always_comb begin
        ex_mem_hazard = '0;
        mem_wb_hazard = '0;

        // execute slot gives way to a bubble on conflict or flush
        ex_mem_hazard[HAZD_NO_OP_BIT] = load_use | flush;
        ex_mem_hazard[HAZD_HOLD_BIT]  = halt;   // memory-stage instruction frozen

        // write-back idles while the memory stage is frozen
        mem_wb_hazard[HAZD_HOLD_BIT]  = halt;
        mem_wb_hazard[HAZD_NO_OP_BIT] = halt;
    end

endmodule

//--- logic/mem_wb_reg.sv
`timescale 1ns/100ps

module mem_wb_reg import pipe_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,

    input  hazard_ctrl_t hazard_control,        // [HAZD_HOLD_BIT] keep wb data
                                                // [HAZD_NO_OP_BIT] silence wb stage
    input  mem_ctrl_t    mem_ctrl,              // from ex_mem_reg

    output logic         wb_no_op,              // for general_reg, blocks the write
    output logic         wb_reg_write_enable,   // for general_reg and forwarding
    output logic         wb_mem_read_enable,    // selects memory data for write-back

    input  word_t        mem_alu_result,        // from ex_mem_reg
    output word_t        wb_alu_result,         // write-back value of alu ops

    input  word_t        mem_read_data,         // from data_mem
    output word_t        wb_mem_read_data,      // write-back value of loads

    input  reg_idx_t     mem_dest_reg_idx,      // from ex_mem_reg
    output reg_idx_t     wb_dest_reg_idx        // for general_reg and forwarding
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_no_op            <= 1'b1;        // empty after reset
            wb_reg_write_enable <= 1'b0;
            wb_mem_read_enable  <= 1'b0;
            wb_alu_result       <= '0;
            wb_mem_read_data    <= '0;
            wb_dest_reg_idx     <= '0;
        end else begin
            wb_reg_write_enable <= mem_ctrl.reg_write_enable;  // tracked even on hold
            if (!hazard_control[HAZD_HOLD_BIT]) begin
                wb_mem_read_enable <= mem_ctrl.mem_read_enable;
                wb_alu_result      <= mem_alu_result;
                wb_mem_read_data   <= mem_read_data;
                wb_dest_reg_idx    <= mem_dest_reg_idx;
            end

            // halt forces a bubble so the held instruction is not written twice
            wb_no_op <= hazard_control[HAZD_NO_OP_BIT] | mem_ctrl.no_op;
        end
    end

endmodule

//--- logic/mem_wb_top.sv
`timescale 1ns/100ps

module mem_wb_top import pipe_pkg::*; #(
    parameter int DMEM_WORDS = 256          // data memory depth in words
) (
    input  logic      clk,
    input  logic      rst_n,

    input  logic      ex_valid,             // one pulse per execute-stage instruction
    input  mem_ctrl_t ex_ctrl,
    input  word_t     ex_alu_result,
    input  word_t     ex_store_data,
    input  reg_idx_t  ex_dest_reg_idx,
    input  reg_idx_t  ex_src_a_idx,
    input  reg_idx_t  ex_src_b_idx,

    input  logic      halt,
    input  logic      flush,

    output word_t     operand_a,            // forwarded sources for execute
    output word_t     operand_b,
    output logic      stall
);

    mem_ctrl_t    mem_ctrl;                 // memory stage
    word_t        mem_alu_result;
    word_t        mem_store_data;
    reg_idx_t     mem_dest_reg_idx;
    word_t        mem_read_data;

    logic         wb_no_op;                 // write-back stage
    logic         wb_reg_write_enable;
    logic         wb_mem_read_enable;
    word_t        wb_alu_result;
    word_t        wb_mem_read_data;
    reg_idx_t     wb_dest_reg_idx;
    word_t        wb_data;

    word_t        rd_a_data;                // register file reads
    word_t        rd_b_data;

    hazard_ctrl_t ex_mem_hazard;
    hazard_ctrl_t mem_wb_hazard;

    ex_mem_reg u_ex_mem_reg (
        .clk              (clk),
        .rst_n            (rst_n),
        .hazard_control   (ex_mem_hazard),
        .ex_valid         (ex_valid),
        .ex_ctrl          (ex_ctrl),
        .mem_ctrl         (mem_ctrl),
        .ex_alu_result    (ex_alu_result),
        .mem_alu_result   (mem_alu_result),
        .ex_store_data    (ex_store_data),
        .mem_store_data   (mem_store_data),
        .ex_dest_reg_idx  (ex_dest_reg_idx),
        .mem_dest_reg_idx (mem_dest_reg_idx)
    );

    data_mem #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_data_mem (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_ctrl       (mem_ctrl),
        .hazard_control (ex_mem_hazard),    // hold of the register feeding memory
        .mem_alu_result (mem_alu_result),
        .mem_store_data (mem_store_data),
        .mem_read_data  (mem_read_data)
    );

    mem_wb_reg u_mem_wb_reg (
        .clk                 (clk),
        .rst_n               (rst_n),
        .hazard_control      (mem_wb_hazard),
        .mem_ctrl            (mem_ctrl),
        .wb_no_op            (wb_no_op),
        .wb_reg_write_enable (wb_reg_write_enable),
        .wb_mem_read_enable  (wb_mem_read_enable),
        .mem_alu_result      (mem_alu_result),
        .wb_alu_result       (wb_alu_result),
        .mem_read_data       (mem_read_data),
        .wb_mem_read_data    (wb_mem_read_data),
        .mem_dest_reg_idx    (mem_dest_reg_idx),
        .wb_dest_reg_idx     (wb_dest_reg_idx)
    );

    general_reg u_general_reg (
        .clk                 (clk),
        .rst_n               (rst_n),
        .wb_no_op            (wb_no_op),
        .wb_reg_write_enable (wb_reg_write_enable),
        .wb_mem_read_enable  (wb_mem_read_enable),
        .wb_alu_result       (wb_alu_result),
        .wb_mem_read_data    (wb_mem_read_data),
        .wb_dest_reg_idx     (wb_dest_reg_idx),
        .rd_a_idx            (ex_src_a_idx),
        .rd_b_idx            (ex_src_b_idx),
        .rd_a_data           (rd_a_data),
        .rd_b_data           (rd_b_data),
        .wb_data             (wb_data)
    );

    forwarding_unit u_forwarding_unit (
        .ex_src_a_idx        (ex_src_a_idx),
        .ex_src_b_idx        (ex_src_b_idx),
        .mem_ctrl            (mem_ctrl),
        .mem_alu_result      (mem_alu_result),
        .mem_dest_reg_idx    (mem_dest_reg_idx),
        .wb_no_op            (wb_no_op),
        .wb_reg_write_enable (wb_reg_write_enable),
        .wb_dest_reg_idx     (wb_dest_reg_idx),
        .wb_data             (wb_data),
        .rd_a_data           (rd_a_data),
        .rd_b_data           (rd_b_data),
        .operand_a           (operand_a),
        .operand_b           (operand_b)
    );

    hazard_unit u_hazard_unit (
        .ex_valid         (ex_valid),
        .ex_src_a_idx     (ex_src_a_idx),
        .ex_src_b_idx     (ex_src_b_idx),
        .mem_ctrl         (mem_ctrl),
        .mem_dest_reg_idx (mem_dest_reg_idx),
        .halt             (halt),
        .flush            (flush),
        .stall            (stall),
        .ex_mem_hazard    (ex_mem_hazard),
        .mem_wb_hazard    (mem_wb_hazard)
    );

endmodule

//--- logic/pipe_pkg.sv
package pipe_pkg;

    // datapath width, fixed by the instruction set
    localparam int ISA_WIDTH           = 32;
    localparam int REG_FILE_ADDR_WIDTH = 5;            // 32 general registers

    typedef logic [ISA_WIDTH-1:0]           word_t;    // one datapath word
    typedef logic [REG_FILE_ADDR_WIDTH-1:0] reg_idx_t; // register index

    // per-stage control from the hazard unit
    typedef logic [1:0] hazard_ctrl_t;

    localparam int HAZD_HOLD_BIT  = 0;                 // stage keeps its contents
    localparam int HAZD_NO_OP_BIT = 1;                 // outgoing instruction becomes a bubble

    // control bits carried from execute into memory
    // the first three continue into write-back
    typedef struct packed {
        logic no_op;                                   // slot holds no instruction
        logic reg_write_enable;                        // result goes to the register file
        logic mem_read_enable;                         // load, result comes from memory
        logic mem_write_enable;                        // store
    } mem_ctrl_t;

    // control pattern of an empty slot
    localparam mem_ctrl_t MEM_CTRL_BUBBLE = '{
        no_op:            1'b1,
        reg_write_enable: 1'b0,
        mem_read_enable:  1'b0,
        mem_write_enable: 1'b0
    };

endpackage

//--- sim/tb_mem_wb.sv
`timescale 1ns/100ps

module tb_mem_wb import pipe_pkg::*; ();

    localparam int DMEM_WORDS  = 16;                // small depth so addresses alias often
    localparam int CHAIN_LEN   = 24;
    localparam int LU_ROUNDS   = 4;                 // seven instructions per round
    localparam int SL_ROUNDS   = 6;                 // five instructions per round
    localparam int HALT_LEN    = 12;
    localparam int FLUSH_LEN   = 16;
    localparam int MIX_LEN     = 300;
    localparam int SWEEP_LEN   = 16 + 2 * DMEM_WORDS;
    localparam int HALT_CAP    = 64;                // halt cycles over the whole run
    localparam int INSTR_TOTAL = CHAIN_LEN + 7 * LU_ROUNDS + 5 * SL_ROUNDS + HALT_LEN
                               + FLUSH_LEN + MIX_LEN + 3 * SWEEP_LEN;
    localparam int CYCLE_LIMIT = 2 * INSTR_TOTAL + HALT_CAP + 64;  // slack for reset and drains

    localparam logic [1:0] OP_ALU   = 2'd0;        // rd = ra + imm as does code 3
    localparam logic [1:0] OP_LOAD  = 2'd1;        // rd = mem[ra + imm]
    localparam logic [1:0] OP_STORE = 2'd2;        // mem[ra + imm] = rb
    localparam reg_idx_t   R0       = '0;
    localparam reg_idx_t   R31      = 5'd31;

    typedef struct packed {
        logic [1:0] op;
        reg_idx_t   dest;
        reg_idx_t   src_a;
        reg_idx_t   src_b;
        word_t      imm;
    } instr_t;

    logic      clk;
    logic      rst_n;
    logic      ex_valid;
    logic      halt;
    logic      flush;
    instr_t    cur;                                 // instruction held by the execute model
    mem_ctrl_t ex_ctrl;
    word_t     ex_alu_result;
    word_t     ex_store_data;
    reg_idx_t  ex_dest_reg_idx;
    reg_idx_t  ex_src_a_idx;
    reg_idx_t  ex_src_b_idx;
    word_t     operand_a;
    word_t     operand_b;
    logic      stall;

    word_t       model_regs [32];                   // architectural registers
    word_t       model_mem  [DMEM_WORDS];           // architectural memory
    logic [31:0] lfsr;
    string       test_name;
    int          errors;
    int          checks;
    int          tests;
    int          err_mark;
    int          cycles;
    int          halt_used;

    mem_wb_top #(.DMEM_WORDS(DMEM_WORDS)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic mem_ctrl_t ctrl_of(input logic [1:0] op);
        mem_ctrl_t c;
        c.no_op            = 1'b0;
        c.reg_write_enable = (op != OP_STORE);
        c.mem_read_enable  = (op == OP_LOAD);
        c.mem_write_enable = (op == OP_STORE);
        return c;
    endfunction

    // execute stage model adds the immediate to the forwarded operand
    assign ex_ctrl         = ctrl_of(cur.op);
    assign ex_dest_reg_idx = cur.dest;
    assign ex_src_a_idx    = cur.src_a;
    assign ex_src_b_idx    = cur.src_b;
    assign ex_alu_result   = operand_a + cur.imm;
    assign ex_store_data   = operand_b;

    // galois lfsr over x^32 + x^22 + x^2 + x + 1 stepped once per bit taken
    function automatic word_t rand_bits(input int n);
        word_t value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return value;
    endfunction

    function automatic int word_index(input word_t addr);
        return int'((addr >> 2) % DMEM_WORDS);      // word index aliased by the depth
    endfunction

    // architectural effect of one accepted instruction
    function automatic void ref_exec(input instr_t ins);
        word_t addr;
        addr = model_regs[ins.src_a] + ins.imm;
        if (ins.op == OP_STORE) begin
            model_mem[word_index(addr)] = model_regs[ins.src_b];
        end else if (ins.dest != R0) begin
            model_regs[ins.dest] = (ins.op == OP_LOAD) ? model_mem[word_index(addr)] : addr;
        end
    endfunction

    function automatic instr_t build_instr(input logic [1:0] op, input reg_idx_t dest,
                                           input reg_idx_t a, input reg_idx_t b,
                                           input word_t imm);
        return '{op: op, dest: dest, src_a: a, src_b: b, imm: imm};
    endfunction

    function automatic instr_t rand_instr();
        instr_t ins;
        ins.op    = 2'(rand_bits(2));
        ins.dest  = reg_idx_t'(rand_bits(3));       // few registers give many hazards
        ins.src_a = reg_idx_t'(rand_bits(3));
        ins.src_b = reg_idx_t'(rand_bits(3));
        ins.imm   = rand_bits(16);
        return ins;
    endfunction

    task automatic check_operand(input string port, input reg_idx_t idx, input word_t actual);
        word_t expected;
        expected = model_regs[idx];
        checks++;
        if (actual !== expected) begin
            $display("mismatch %s %s r%0d: expected %h actual %h",
                     test_name, port, idx, expected, actual);
            errors++;
        end
    endtask

    // compare at the falling edge and retire what the next rising edge accepts
    always @(negedge clk) begin
        if (rst_n && ex_valid && !stall) begin
            check_operand("operand_a", ex_src_a_idx, operand_a);
            check_operand("operand_b", ex_src_b_idx, operand_b);
            if (!flush) begin
                ref_exec(cur);
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run still busy after %0d cycles", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // present one instruction until the pipeline takes it or flush drops it
    task automatic issue(input instr_t ins, input logic squash, input int halt_cycles,
                         output int stalls);
        int   halt_left;
        logic taken;
        halt_left = halt_cycles;
        stalls    = 0;
        cur       = ins;
        ex_valid  = 1'b1;
        flush     = squash;
        do begin
            halt      = (halt_left > 0);            // halt level for the first cycles
            halt_left = halt_left - 1;
            @(negedge clk);
            taken = !stall;
            if (stall) begin
                stalls++;
            end
            @(posedge clk);
            #10;
        end while (!taken);
        halt_used += halt_cycles;
    endtask

    task automatic issue_expect(input instr_t ins, input int want);
        int got;
        issue(ins, 1'b0, 0, got);
        if (got != want) begin
            $display("mismatch %s stall cycles: expected %0d actual %0d", test_name, want, got);
            errors++;
        end
    endtask

    task automatic drain(input int n);
        ex_valid = 1'b0;
        halt     = 1'b0;
        flush    = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #10;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_mark  = errors;
    endtask

    task automatic end_test();
        drain(3);
        tests++;
        $display("%-10s %s, %0d errors", test_name, (errors == err_mark) ? "ok" : "FAILED",
                 errors - err_mark);
    endtask

    // all registers in pairs and every memory word through r31
    task automatic sweep();
        int s;
        for (int i = 0; i < 16; i++) begin
            issue(build_instr(OP_ALU, R0, reg_idx_t'(2 * i), reg_idx_t'(2 * i + 1), '0),
                  1'b0, 0, s);
        end
        for (int w = 0; w < DMEM_WORDS; w++) begin
            issue_expect(build_instr(OP_LOAD, R31, R0, R0, word_t'(4 * w)), 0);
            issue_expect(build_instr(OP_ALU, R0, R31, R0, '0), 1);  // load-use on r31
        end
    endtask

    task automatic test_chain();
        reg_idx_t prev;
        reg_idx_t prev2;
        reg_idx_t dest;
        begin_test("alu_chain");
        prev  = 5'd1;
        prev2 = 5'd2;
        for (int i = 0; i < CHAIN_LEN; i++) begin
            dest = (i % 6 == 5) ? R0 : reg_idx_t'(1 + rand_bits(4));  // r0 write now and then
            issue_expect(build_instr(OP_ALU, dest, prev, prev2, rand_bits(32)), 0);
            prev2 = prev;                           // read two back and forwarded from write-back
            prev  = dest;
        end
        end_test();
    endtask

    task automatic test_load_use();
        reg_idx_t base;
        reg_idx_t data;
        reg_idx_t dst;
        word_t    off;
        begin_test("load_use");
        for (int r = 0; r < LU_ROUNDS; r++) begin
            base = reg_idx_t'(3 + r);
            data = reg_idx_t'(8 + r);
            dst  = reg_idx_t'(16 + r);
            off  = rand_bits(6) << 2;
            issue_expect(build_instr(OP_ALU, base, R0, R0, rand_bits(32)), 0);
            issue_expect(build_instr(OP_ALU, data, R0, R0, rand_bits(32)), 0);
            issue_expect(build_instr(OP_STORE, R0, base, data, off), 0);
            issue_expect(build_instr(OP_LOAD, dst, base, R0, off), 0);
            if (r % 2 == 0) begin                   // reader on port a or port b by round
                issue_expect(build_instr(OP_ALU, R0, dst, R0, '0), 1);
            end else begin
                issue_expect(build_instr(OP_ALU, R0, R0, dst, '0), 1);
            end
            issue_expect(build_instr(OP_LOAD, R0, base, R0, off), 0);   // load into r0
            issue_expect(build_instr(OP_ALU, 5'd1, R0, data, 32'd1), 0); // no conflict behind it
        end
        end_test();
    endtask

    task automatic test_store_load();
        reg_idx_t base;
        reg_idx_t data;
        reg_idx_t dst;
        word_t    off;
        word_t    alias_off;
        begin_test("st_ld");
        for (int r = 0; r < SL_ROUNDS; r++) begin
            base      = reg_idx_t'(1 + rand_bits(3));
            data      = reg_idx_t'(9 + rand_bits(3));
            dst       = reg_idx_t'(17 + rand_bits(3));
            off       = rand_bits(8) << 2;
            alias_off = off + word_t'(4 * DMEM_WORDS) * rand_bits(2);  // same word at another alias
            issue_expect(build_instr(OP_ALU, base, R0, R0, rand_bits(32)), 0);
            issue_expect(build_instr(OP_ALU, data, R0, R0, rand_bits(32)), 0);
            issue_expect(build_instr(OP_STORE, R0, base, data, off), 0);
            issue_expect(build_instr(OP_LOAD, dst, base, R0, alias_off), 0);
            issue_expect(build_instr(OP_ALU, R0, dst, R0, '0), 1);
        end
        end_test();
    endtask

    task automatic test_halt();
        int s;
        int hold;
        begin_test("halt");
        for (int i = 0; i < HALT_LEN; i++) begin
            hold = (i == 4 || i == 9) ? 1 + int'(rand_bits(3)) : 0;
            issue(rand_instr(), 1'b0, hold, s);
        end
        sweep();
        end_test();
    endtask

    task automatic test_flush();
        int s;
        begin_test("flush");
        for (int i = 0; i < FLUSH_LEN; i++) begin
            issue(rand_instr(), rand_bits(1) != '0, 0, s);  // about half squashed
        end
        sweep();
        end_test();
    endtask

    task automatic test_mix();
        int   s;
        int   hold;
        logic squash;
        begin_test("mix");
        for (int i = 0; i < MIX_LEN; i++) begin
            squash = (rand_bits(3) == '0);
            hold   = 0;
            if (rand_bits(4) == '0 && halt_used + 4 <= HALT_CAP) begin
                hold = 1 + int'(rand_bits(2));
            end
            issue(rand_instr(), squash, hold, s);
        end
        sweep();
        end_test();
    endtask

    initial begin
        lfsr      = 32'h87cc_a8c9;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        err_mark  = 0;
        cycles    = 0;
        halt_used = 0;
        test_name = "reset";
        rst_n     = 1'b0;
        ex_valid  = 1'b0;
        halt      = 1'b0;
        flush     = 1'b0;
        cur       = '0;
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
        foreach (model_mem[i]) begin
            model_mem[i] = '0;
        end
        repeat (3) @(posedge clk);
        #10;
        rst_n = 1'b1;

        test_chain();
        test_load_use();
        test_store_load();
        test_halt();
        test_flush();
        test_mix();

        $display("summary: %0d tests, %0d checks, %0d errors, %0d halt cycles, %0d cycles",
                 tests, checks, errors, halt_used, cycles);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog.f
logic/pipe_pkg.sv
logic/ex_mem_reg.sv
logic/data_mem.sv
logic/mem_wb_reg.sv
logic/general_reg.sv
logic/forwarding_unit.sv
logic/hazard_unit.sv
logic/mem_wb_top.sv
sim/tb_mem_wb.sv
